//--- src/bridge_params.svh
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// memory side
`define BRIDGE_PADDR_W 40   // physical address bits from the cce
`define BRIDGE_BLOCK_W 512  // one cache block

// axi side
`define BRIDGE_AXI_ADDR_W 64  // paddr is zero extended to this
`define BRIDGE_BEAT_W 64      // rdata / wdata width

// log2 of bytes per beat
// size fields below this are not supported
`define BRIDGE_BEAT_BYTES_LG 3

// beats per block and index width
`define BRIDGE_BEATS 8
`define BRIDGE_BEAT_CNT_W 3

`endif

//--- src/bridge_pkg.sv
`include "bridge_params.svh"

package bridge_pkg;

  // memory message kinds, uncached ones take the same axi path
  typedef enum logic [1:0] {
    mem_rd    = 2'b00,  // cached read
    mem_uc_rd = 2'b01,  // uncached read
    mem_wr    = 2'b10,  // cached writeback
    mem_uc_wr = 2'b11   // uncached write
  } mem_msg_type_e;

  typedef struct packed {
    mem_msg_type_e              msg_type;
    logic [`BRIDGE_PADDR_W-1:0] addr;
    logic [2:0]                 size;  // log2 of bytes, 3 up to 6
    logic [5:0]                 tag;   // requester id, echoed in the response
  } mem_header_t;

  // command and response share the layout
  typedef struct packed {
    mem_header_t                header;
    logic [`BRIDGE_BLOCK_W-1:0] data;  // write block or read block
  } mem_msg_t;

endpackage

//--- src/addr_req_if.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

// address phase request, one per axi address channel
interface addr_req_if;
  logic                       req;   // start pulse from control
  logic [`BRIDGE_PADDR_W-1:0] addr;
  logic [2:0]                 size;  // log2 bytes, as in the header
  logic                       done;  // pulse when the ax handshake completes

  modport ctrl (output req, output addr, output size, input done);

  modport issuer (input req, input addr, input size, output done);
endinterface

//--- src/axi_addr_issue.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

module axi_addr_issue (
  input  logic                          aclk_i,
  input  logic                          aresetn_i,
  addr_req_if.issuer                    req_if,
  output logic [`BRIDGE_AXI_ADDR_W-1:0] axaddr_o,
  output logic [7:0]                    axlen_o,
  output logic [2:0]                    axsize_o,
  output logic                          axvalid_o,
  input  logic                          axready_i
);

  logic [2:0] len_lg;  // log2 of the beat count

  assign len_lg = req_if.size - 3'(`BRIDGE_BEAT_BYTES_LG);

  // payload is captured once per request
  always_ff @(posedge aclk_i) begin
    if (req_if.req) begin
      axaddr_o <= `BRIDGE_AXI_ADDR_W'(req_if.addr);  // zero extend
      axsize_o <= req_if.size;
      axlen_o  <= 8'((9'd1 << len_lg) - 9'd1);      // beats minus one
    end
  end

  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      axvalid_o <= 1'b0;
    end else if (req_if.req) begin
      axvalid_o <= 1'b1;
    end else if (axready_i) begin
      axvalid_o <= 1'b0;  // drops the cycle after the handshake
    end
  end

  assign req_if.done = axvalid_o & axready_i;

  // the slave may sample at any stalled cycle
  payload_stable_a: assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    axvalid_o && !axready_i |=> $stable({axaddr_o, axlen_o, axsize_o}));

endmodule

//--- src/read_beat_sipo.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

module read_beat_sipo (
  input  logic                       aclk_i,
  input  logic                       aresetn_i,
  input  logic                       beat_take_i,
  input  logic [`BRIDGE_BEAT_W-1:0]  beat_data_i,
  input  logic                       last_i,
  output logic [`BRIDGE_BLOCK_W-1:0] block_o,
  output logic                       full_v_o,
  input  logic                       release_i
);

  logic [`BRIDGE_BEAT_CNT_W-1:0] slot_r;   // next slot to fill
  logic [`BRIDGE_BLOCK_W-1:0]    block_r;
  logic                          full_r;

  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      slot_r <= '0;
      full_r <= 1'b0;
    end else begin
      if (beat_take_i) begin
        slot_r <= last_i ? '0 : slot_r + 1'b1;  // rewind for the next burst
      end
      if (beat_take_i && last_i) begin
        full_r <= 1'b1;
      end else if (release_i) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk_i) begin
    if (beat_take_i) begin
      if (slot_r == '0) begin
        // first beat also zeroes the upper slots of a short burst
        block_r <= `BRIDGE_BLOCK_W'(beat_data_i);
      end else begin
        block_r[slot_r*`BRIDGE_BEAT_W +: `BRIDGE_BEAT_W] <= beat_data_i;
      end
    end
  end

  assign full_v_o = full_r;
  assign block_o  = full_r ? block_r : '0;  // zero data outside a read response

  no_take_when_full_a: assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    beat_take_i |-> !full_r);

endmodule

//--- src/write_beat_piso.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

module write_beat_piso (
  input  logic                       aclk_i,
  input  logic                       aresetn_i,
  input  logic                       load_i,
  input  logic [`BRIDGE_BLOCK_W-1:0] block_i,
  input  logic [`BRIDGE_BEAT_CNT_W:0] beats_i,  // 1 up to a full block
  output logic                       beat_v_o,
  output logic [`BRIDGE_BEAT_W-1:0]  beat_o,
  output logic                       last_o,
  input  logic                       next_i
);

  logic [`BRIDGE_BLOCK_W-1:0]    block_r;
  logic [`BRIDGE_BEAT_CNT_W-1:0] idx_r;       // beat on the bus
  logic [`BRIDGE_BEAT_CNT_W-1:0] last_idx_r;  // index of the final beat
  logic                          beat_v_r;

  always_ff @(posedge aclk_i) begin
    if (load_i) begin
      block_r <= block_i;
    end
  end

  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      beat_v_r   <= 1'b0;
      idx_r      <= '0;
      last_idx_r <= '0;
    end else if (load_i) begin
      beat_v_r   <= 1'b1;
      idx_r      <= '0;  // beat 0 goes first
      last_idx_r <= `BRIDGE_BEAT_CNT_W'(beats_i - 1'b1);
    end else if (next_i && beat_v_r) begin
      if (last_o) begin
        beat_v_r <= 1'b0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  assign beat_v_o = beat_v_r;
  assign beat_o   = block_r[idx_r*`BRIDGE_BEAT_W +: `BRIDGE_BEAT_W];
  assign last_o   = beat_v_r && (idx_r == last_idx_r);

  no_load_when_busy_a: assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    load_i |-> !beat_v_r);

endmodule

//--- src/bridge_ctrl.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

module bridge_ctrl (
  input  logic                         aclk_i,
  input  logic                         aresetn_i,
  input  bridge_pkg::mem_msg_t         mem_cmd_i,
  input  logic                         mem_cmd_v_i,
  output logic                         mem_cmd_ready_o,
  output bridge_pkg::mem_header_t      mem_resp_header_o,
  output logic                         mem_resp_v_o,
  input  logic                         mem_resp_yumi_i,
  addr_req_if.ctrl                     rd_req,
  addr_req_if.ctrl                     wr_req,
  input  logic                         rvalid_i,
  input  logic                         rlast_i,
  output logic                         rready_o,
  output logic                         sipo_take_o,
  input  logic                         sipo_full_v_i,
  output logic                         sipo_release_o,
  output logic                         piso_load_o,
  output logic [`BRIDGE_BEAT_CNT_W:0]  piso_beats_o,
  input  logic                         piso_beat_v_i,
  input  logic                         piso_last_i,
  output logic                         wvalid_o,
  input  logic                         wready_i,
  output logic                         wlast_o,
  output logic                         piso_next_o,
  input  logic                         bvalid_i,
  output logic                         bready_o
);

  typedef enum logic [2:0] {
    st_idle, st_read, st_read_resp, st_write_addr, st_write_data, st_write_resp, st_resp_hold
  } state_e;

  state_e                  state_r, state_n;
  bridge_pkg::mem_header_t hdr_r;      // echoed in the response
  logic                    accept;
  logic                    cmd_is_rd;  // otherwise a write
  logic [2:0]              beats_lg;

  assign cmd_is_rd = mem_cmd_i.header.msg_type inside {bridge_pkg::mem_rd, bridge_pkg::mem_uc_rd};
  assign mem_cmd_ready_o = (state_r == st_idle);
  assign accept = mem_cmd_v_i & mem_cmd_ready_o;

  // issuers register the live header on the start pulse
  assign rd_req.req  = accept & cmd_is_rd;
  assign rd_req.addr = mem_cmd_i.header.addr;
  assign rd_req.size = mem_cmd_i.header.size;
  assign wr_req.req  = accept & ~cmd_is_rd;
  assign wr_req.addr = mem_cmd_i.header.addr;
  assign wr_req.size = mem_cmd_i.header.size;

  // write block is loaded together with the aw request
  assign beats_lg     = mem_cmd_i.header.size - 3'(`BRIDGE_BEAT_BYTES_LG);
  assign piso_load_o  = wr_req.req;
  assign piso_beats_o = (`BRIDGE_BEAT_CNT_W+1)'(1) << beats_lg;

  always_ff @(posedge aclk_i) begin
    if (accept) begin
      hdr_r <= mem_cmd_i.header;
    end
  end

  assign rready_o    = (state_r == st_read);
  assign sipo_take_o = rvalid_i & rready_o;
  assign wvalid_o    = (state_r == st_write_data) & piso_beat_v_i;
  assign wlast_o     = wvalid_o & piso_last_i;
  assign piso_next_o = wvalid_o & wready_i;     // w handshake
  assign bready_o    = (state_r == st_write_resp);

  // write response carries zero data since the sipo is empty then
  assign mem_resp_v_o = ((state_r == st_read_resp) & sipo_full_v_i)
                      | (state_r == st_resp_hold);
  assign mem_resp_header_o = hdr_r;
  assign sipo_release_o = mem_resp_yumi_i & (state_r == st_read_resp);

  always_comb begin
    state_n = state_r;
    case (state_r)
      st_idle: begin
        if (accept) state_n = cmd_is_rd ? st_read : st_write_addr;
      end
      st_read:       if (sipo_take_o && rlast_i) state_n = st_read_resp;
      st_read_resp:  if (mem_resp_yumi_i) state_n = st_idle;
      st_write_addr: if (wr_req.done) state_n = st_write_data;  // aw accepted
      st_write_data: if (piso_next_o && piso_last_i) state_n = st_write_resp;
      st_write_resp: if (bvalid_i) state_n = st_resp_hold;
      st_resp_hold:  if (mem_resp_yumi_i) state_n = st_idle;
      default:       state_n = st_idle;
    endcase
  end

  always_ff @(posedge aclk_i) begin
    if (!aresetn_i) begin
      state_r <= st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  resp_held_a: assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    mem_resp_v_o && !mem_resp_yumi_i |=> mem_resp_v_o && $stable(mem_resp_header_o));

  // ar handshake only happens while the read burst is pending
  ar_in_read_a: assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    rd_req.done |-> state_r == st_read);

endmodule

//--- src/mem_axi_bridge.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

module mem_axi_bridge (
  input  logic                          aclk_i,
  input  logic                          aresetn_i,
  input  bridge_pkg::mem_msg_t          mem_cmd_i,
  input  logic                          mem_cmd_v_i,
  output logic                          mem_cmd_ready_o,
  output bridge_pkg::mem_msg_t          mem_resp_o,
  output logic                          mem_resp_v_o,
  input  logic                          mem_resp_yumi_i,
  output logic [`BRIDGE_AXI_ADDR_W-1:0] awaddr_o,
  output logic [7:0]                    awlen_o,
  output logic [2:0]                    awsize_o,
  output logic                          awvalid_o,
  input  logic                          awready_i,
  output logic [`BRIDGE_BEAT_W-1:0]     wdata_o,
  output logic                          wlast_o,
  output logic                          wvalid_o,
  input  logic                          wready_i,
  input  logic                          bvalid_i,
  output logic                          bready_o,
  output logic [`BRIDGE_AXI_ADDR_W-1:0] araddr_o,
  output logic [7:0]                    arlen_o,
  output logic [2:0]                    arsize_o,
  output logic                          arvalid_o,
  input  logic                          arready_i,
  input  logic [`BRIDGE_BEAT_W-1:0]     rdata_i,
  input  logic                          rlast_i,
  input  logic                          rvalid_i,
  output logic                          rready_o
);

  addr_req_if rd_req_if ();
  addr_req_if wr_req_if ();

  logic                        sipo_take, sipo_full_v, sipo_release;
  logic                        piso_load, piso_beat_v, piso_last, piso_next;
  logic [`BRIDGE_BEAT_CNT_W:0] piso_beats;

  bridge_ctrl i_ctrl (
    .aclk_i, .aresetn_i, .mem_cmd_i, .mem_cmd_v_i, .mem_cmd_ready_o,
    .mem_resp_header_o (mem_resp_o.header),
    .mem_resp_v_o, .mem_resp_yumi_i,
    .rd_req (rd_req_if.ctrl), .wr_req (wr_req_if.ctrl),
    .rvalid_i, .rlast_i, .rready_o,
    .sipo_take_o (sipo_take), .sipo_full_v_i (sipo_full_v), .sipo_release_o (sipo_release),
    .piso_load_o (piso_load), .piso_beats_o (piso_beats),
    .piso_beat_v_i (piso_beat_v), .piso_last_i (piso_last),
    .wvalid_o, .wready_i, .wlast_o, .piso_next_o (piso_next),
    .bvalid_i, .bready_o
  );

  axi_addr_issue i_ar_issue (
    .aclk_i, .aresetn_i, .req_if (rd_req_if.issuer),
    .axaddr_o (araddr_o), .axlen_o (arlen_o), .axsize_o (arsize_o),
    .axvalid_o (arvalid_o), .axready_i (arready_i)
  );

  axi_addr_issue i_aw_issue (
    .aclk_i, .aresetn_i, .req_if (wr_req_if.issuer),
    .axaddr_o (awaddr_o), .axlen_o (awlen_o), .axsize_o (awsize_o),
    .axvalid_o (awvalid_o), .axready_i (awready_i)
  );

  // rdata goes straight in, the block is the response data
  read_beat_sipo i_sipo (
    .aclk_i, .aresetn_i,
    .beat_take_i (sipo_take), .beat_data_i (rdata_i), .last_i (rlast_i),
    .block_o (mem_resp_o.data), .full_v_o (sipo_full_v), .release_i (sipo_release)
  );

  write_beat_piso i_piso (
    .aclk_i, .aresetn_i,
    .load_i (piso_load), .block_i (mem_cmd_i.data), .beats_i (piso_beats),
    .beat_v_o (piso_beat_v), .beat_o (wdata_o), .last_o (piso_last), .next_i (piso_next)
  );

endmodule

//--- bench/bridge_checker.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

module bridge_checker (
  input  logic                          aclk_i,
  input  logic                          aresetn_i,
  input  bridge_pkg::mem_msg_t          cmd_i,
  input  logic                          cmd_v_i,
  input  logic                          cmd_ready_i,
  input  bridge_pkg::mem_msg_t          resp_i,
  input  logic                          resp_v_i,
  input  logic                          resp_yumi_i,
  input  logic [`BRIDGE_AXI_ADDR_W-1:0] araddr_i,
  input  logic [7:0]                    arlen_i,
  input  logic [2:0]                    arsize_i,
  input  logic                          arvalid_i,
  input  logic                          arready_i,
  input  logic [`BRIDGE_AXI_ADDR_W-1:0] awaddr_i,
  input  logic [7:0]                    awlen_i,
  input  logic [2:0]                    awsize_i,
  input  logic                          awvalid_i,
  input  logic                          awready_i,
  input  logic                          wvalid_i,
  input  logic                          wready_i,
  input  logic                          wlast_i,
  input  logic                          rready_i,
  input  logic                          bready_i,
  output int                            value_errs_o,
  output int                            proto_errs_o,
  output int                            resp_cnt_o
);

  logic [`BRIDGE_BEAT_W-1:0] shadow [logic [63:0]];  // words written so far by byte address
  bridge_pkg::mem_msg_t      exp_q [$];               // expected responses in command order
  bridge_pkg::mem_header_t   cur_hdr;                 // command in flight
  bridge_pkg::mem_msg_t      prev_resp;
  logic                      prev_hold = 1'b0;        // response offered but not taken
  logic                      started = 1'b0;
  int                        w_beat = 0;
  int                        value_errs = 0;
  int                        proto_errs = 0;
  int                        resp_cnt = 0;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;
  assign resp_cnt_o   = resp_cnt;

  // memory contents before any write
  function automatic logic [63:0] fill_word(logic [63:0] a);
    logic [31:0] lo;
    lo = a[31:0] ^ 32'h5a5a_0000;
    return {lo ^ a[63:32], lo};  // high half also folds in the upper address
  endfunction

  // bytes of the access over bytes per beat, less one
  function automatic int burst_len(logic [2:0] size);
    return ((1 << size) >> `BRIDGE_BEAT_BYTES_LG) - 1;
  endfunction

  function automatic logic [63:0] beat_addr(bridge_pkg::mem_header_t h, int i);
    return 64'(h.addr) + 64'(i << `BRIDGE_BEAT_BYTES_LG);  // incrementing burst
  endfunction

  // reference model of one response
  function automatic bridge_pkg::mem_msg_t expected_resp(bridge_pkg::mem_header_t h);
    bridge_pkg::mem_msg_t m;
    logic [63:0]          a;
    int                   i;
    m.header = h;  // header echoed as is
    m.data   = '0; // writes and unused read slots stay zero
    if (h.msg_type inside {bridge_pkg::mem_rd, bridge_pkg::mem_uc_rd}) begin
      for (i = 0; i <= burst_len(h.size); i++) begin
        a = beat_addr(h, i);
        m.data[i*`BRIDGE_BEAT_W +: `BRIDGE_BEAT_W] = shadow.exists(a) ? shadow[a] : fill_word(a);
      end
    end
    return m;
  endfunction

  task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
    if (got !== want) begin
      $display("[ERROR] %s: got %h expected %h", name, got, want);
      value_errs++;
    end
  endtask

  task automatic accept_cmd();
    int i;
    started = 1'b1;
    cur_hdr = cmd_i.header;
    exp_q.push_back(expected_resp(cmd_i.header));  // before the write lands
    if (cmd_i.header.msg_type inside {bridge_pkg::mem_wr, bridge_pkg::mem_uc_wr}) begin
      for (i = 0; i <= burst_len(cmd_i.header.size); i++) begin
        shadow[beat_addr(cmd_i.header, i)] = cmd_i.data[i*`BRIDGE_BEAT_W +: `BRIDGE_BEAT_W];
      end
    end
  endtask

  task automatic compare_resp();
    bridge_pkg::mem_msg_t want;
    int                   i;
    if (exp_q.size() == 0) begin
      $display("response with tag %0h arrived with no command outstanding", resp_i.header.tag);
      proto_errs++;
    end else begin
      want = exp_q.pop_front();
      check_value("mem_resp_o.header", 64'(resp_i.header), 64'(want.header));
      for (i = 0; i < `BRIDGE_BEATS; i++) begin
        check_value($sformatf("mem_resp_o.data[%0d]", i),
                    resp_i.data[i*`BRIDGE_BEAT_W +: `BRIDGE_BEAT_W],
                    want.data[i*`BRIDGE_BEAT_W +: `BRIDGE_BEAT_W]);
      end
      resp_cnt++;
    end
  endtask

  // everything is sampled at the rising edge before the inputs move
  always @(posedge aclk_i) begin
    if (aresetn_i) begin
      if (!started && (!cmd_ready_i || arvalid_i || awvalid_i || wvalid_i || rready_i
                       || bready_i || resp_v_i)) begin
        $display("handshake outputs left their reset values before the first command");
        proto_errs++;
      end
      if (resp_v_i && cmd_ready_i) begin
        $display("command ready was high while a response was held");
        proto_errs++;
      end
      if (prev_hold && (!resp_v_i || resp_i !== prev_resp)) begin
        $display("response dropped or changed before it was taken");
        proto_errs++;
      end
      if (arvalid_i && arready_i) begin
        check_value("araddr_o", araddr_i, 64'(cur_hdr.addr));  // zero extended
        check_value("arlen_o", 64'(arlen_i), 64'(burst_len(cur_hdr.size)));
        check_value("arsize_o", 64'(arsize_i), 64'(cur_hdr.size));
      end
      if (awvalid_i && awready_i) begin
        check_value("awaddr_o", awaddr_i, 64'(cur_hdr.addr));
        check_value("awlen_o", 64'(awlen_i), 64'(burst_len(cur_hdr.size)));
        check_value("awsize_o", 64'(awsize_i), 64'(cur_hdr.size));
        w_beat = 0;
      end
      if (wvalid_i && wready_i) begin
        check_value("wlast_o", 64'(wlast_i), 64'(w_beat == burst_len(cur_hdr.size)));
        w_beat++;
      end
      if (resp_v_i && resp_yumi_i) compare_resp();
      if (cmd_v_i && cmd_ready_i) accept_cmd();
      prev_hold = resp_v_i && !resp_yumi_i;
      prev_resp = resp_i;
    end
  end

endmodule

//--- bench/tb_mem_axi_bridge.sv
`timescale 1ns/10ps
`include "bridge_params.svh"

module tb_mem_axi_bridge;

  localparam int NUM_RAND = 24;
  localparam int NUM_CMDS = 9 + NUM_RAND;  // directed ones first
  localparam int CLK_NS   = 10;

  logic                          aclk = 1'b0;
  logic                          aresetn = 1'b0;
  bridge_pkg::mem_msg_t          cmd = '0;
  logic                          cmd_v = 1'b0;
  logic                          cmd_ready;
  bridge_pkg::mem_msg_t          resp;
  logic                          resp_v;
  logic                          yumi = 1'b0;
  logic [`BRIDGE_AXI_ADDR_W-1:0] awaddr, araddr;
  logic [7:0]                    awlen, arlen;
  logic [2:0]                    awsize, arsize;
  logic                          awvalid, arvalid, wlast, wvalid, bready, rready;
  logic [`BRIDGE_BEAT_W-1:0]     wdata;
  logic                          awready = 1'b0, wready = 1'b0, arready = 1'b0;
  logic                          bvalid = 1'b0, rvalid = 1'b0, rlast = 1'b0;
  logic [`BRIDGE_BEAT_W-1:0]     rdata = '0;
  integer                        seed = 32'h8a81_d57e;
  int                            value_errs, proto_errs, resp_cnt;

  // slave model state
  logic [`BRIDGE_BEAT_W-1:0]     smem [logic [63:0]];  // keyed by byte address of the word
  logic [63:0]                   rd_addr = '0, wr_addr = '0;
  int                            rd_len = 0, rd_beat = 0, wr_beat = 0;
  logic                          rd_busy = 1'b0, b_pend = 1'b0, r_hold = 1'b0, b_hold = 1'b0;

  always #(CLK_NS/2) aclk = ~aclk;

  mem_axi_bridge i_dut (
    .aclk_i (aclk), .aresetn_i (aresetn),
    .mem_cmd_i (cmd), .mem_cmd_v_i (cmd_v), .mem_cmd_ready_o (cmd_ready),
    .mem_resp_o (resp), .mem_resp_v_o (resp_v), .mem_resp_yumi_i (yumi),
    .awaddr_o (awaddr), .awlen_o (awlen), .awsize_o (awsize), .awvalid_o (awvalid),
    .awready_i (awready), .wdata_o (wdata), .wlast_o (wlast), .wvalid_o (wvalid),
    .wready_i (wready), .bvalid_i (bvalid), .bready_o (bready),
    .araddr_o (araddr), .arlen_o (arlen), .arsize_o (arsize), .arvalid_o (arvalid),
    .arready_i (arready), .rdata_i (rdata), .rlast_i (rlast), .rvalid_i (rvalid),
    .rready_o (rready)
  );

  bridge_checker i_checker (
    .aclk_i (aclk), .aresetn_i (aresetn),
    .cmd_i (cmd), .cmd_v_i (cmd_v), .cmd_ready_i (cmd_ready),
    .resp_i (resp), .resp_v_i (resp_v), .resp_yumi_i (yumi),
    .araddr_i (araddr), .arlen_i (arlen), .arsize_i (arsize),
    .arvalid_i (arvalid), .arready_i (arready),
    .awaddr_i (awaddr), .awlen_i (awlen), .awsize_i (awsize),
    .awvalid_i (awvalid), .awready_i (awready),
    .wvalid_i (wvalid), .wready_i (wready), .wlast_i (wlast),
    .rready_i (rready), .bready_i (bready),
    .value_errs_o (value_errs), .proto_errs_o (proto_errs), .resp_cnt_o (resp_cnt)
  );

  function automatic logic [63:0] fill_word(logic [63:0] a);
    logic [31:0] lo;
    lo = a[31:0] ^ 32'h5a5a_0000;
    return {lo ^ a[63:32], lo};
  endfunction

  function automatic logic random_go();
    return ($random(seed) & 3) != 0;  // three in four cycles
  endfunction

  function automatic logic [`BRIDGE_BLOCK_W-1:0] rand_block();
    logic [`BRIDGE_BLOCK_W-1:0] b;
    int                         i;
    for (i = 0; i < `BRIDGE_BLOCK_W / 32; i++) b[i*32 +: 32] = $random(seed);
    return b;
  endfunction

  // axi slave samples handshakes at the edge and drives new values 1 ns later
  always @(posedge aclk) begin
    r_hold = rvalid && !rready;  // an offered beat stays until taken
    b_hold = bvalid && !bready;
    if (arvalid && arready) begin
      rd_addr = araddr;
      rd_len  = int'(arlen);
      rd_beat = 0;
      rd_busy = 1'b1;
    end
    if (rvalid && rready) begin
      if (rlast) rd_busy = 1'b0;
      rd_beat++;
    end
    if (awvalid && awready) begin
      wr_addr = awaddr;
      wr_beat = 0;
    end
    if (wvalid && wready) begin
      smem[wr_addr + 64'(wr_beat << `BRIDGE_BEAT_BYTES_LG)] = wdata;  // full strobes
      wr_beat++;
      if (wlast) b_pend = 1'b1;
    end
    if (bvalid && bready) b_pend = 1'b0;
    #1;
    arready = random_go();
    awready = random_go();
    wready  = random_go();
    if (!r_hold) begin
      rvalid = rd_busy && random_go();
      rdata  = smem.exists(rd_addr + 64'(rd_beat << `BRIDGE_BEAT_BYTES_LG))
             ? smem[rd_addr + 64'(rd_beat << `BRIDGE_BEAT_BYTES_LG)]
             : fill_word(rd_addr + 64'(rd_beat << `BRIDGE_BEAT_BYTES_LG));
      rlast  = (rd_beat == rd_len);
    end
    if (!b_hold) bvalid = b_pend && random_go();
  end

  // response consumer takes its time
  always @(posedge aclk) begin
    #1;
    yumi = resp_v && (($random(seed) & 1) != 0);
  end

  task automatic run_cmd(bridge_pkg::mem_msg_type_e t, logic [`BRIDGE_PADDR_W-1:0] addr,
                         logic [2:0] size, logic [5:0] tag, logic [`BRIDGE_BLOCK_W-1:0] data);
    cmd.header = '{t, addr, size, tag};
    cmd.data   = data;
    cmd_v      = 1'b1;
    do begin
      @(posedge aclk);
    end while (!cmd_ready);
    #1;
    cmd_v = 1'b0;
  endtask

  initial begin
    logic [`BRIDGE_PADDR_W-1:0] addr;
    logic [2:0]                 size;
    int                         i;
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    run_cmd(bridge_pkg::mem_rd, 40'h00_1000_0040, 3'd6, 6'h01, '0);  // full block
    run_cmd(bridge_pkg::mem_wr, 40'h00_1000_0080, 3'd6, 6'h02, rand_block());
    run_cmd(bridge_pkg::mem_rd, 40'h00_1000_0080, 3'd6, 6'h03, '0);  // reads back the write
    run_cmd(bridge_pkg::mem_rd, 40'h12_3456_7808, 3'd3, 6'h04, '0);  // one beat
    run_cmd(bridge_pkg::mem_wr, 40'h12_3456_7808, 3'd3, 6'h05, rand_block());
    run_cmd(bridge_pkg::mem_rd, 40'h12_3456_7808, 3'd3, 6'h06, '0);
    run_cmd(bridge_pkg::mem_uc_rd, 40'h00_2000_0020, 3'd5, 6'h07, '0);
    run_cmd(bridge_pkg::mem_uc_wr, 40'h00_2000_0030, 3'd4, 6'h08, rand_block());
    run_cmd(bridge_pkg::mem_uc_rd, 40'h00_2000_0020, 3'd5, 6'h09, '0);
    // random mix in four blocks so reads hit earlier writes
    for (i = 0; i < NUM_RAND; i++) begin
      size = 3'(3 + ($random(seed) & 3));
      addr = 40'h00_3000_0000 + 40'(($random(seed) & 3) << 6)
           + (40'(($random(seed) & 7) << 3) & ~((40'd1 << size) - 40'd1));  // size aligned
      run_cmd(bridge_pkg::mem_msg_type_e'(2'($random(seed))), addr, size, 6'(i + 16),
              rand_block());
    end
    wait (resp_cnt == NUM_CMDS);
    repeat (20) @(posedge aclk);  // room for a stray extra response
    $display("errors: %0d value, %0d protocol; responses %0d of %0d",
             value_errs, proto_errs, resp_cnt, NUM_CMDS);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog with a generous per command budget
  initial begin
    #(NUM_CMDS * 200 * CLK_NS);
    $display("timeout: only %0d of %0d responses arrived", resp_cnt, NUM_CMDS);
    $display("errors: %0d value, %0d protocol; responses %0d of %0d",
             value_errs, proto_errs, resp_cnt, NUM_CMDS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
src/bridge_pkg.sv
src/addr_req_if.sv
src/axi_addr_issue.sv
src/read_beat_sipo.sv
src/write_beat_piso.sv
src/bridge_ctrl.sv
src/mem_axi_bridge.sv
bench/bridge_checker.sv
bench/tb_mem_axi_bridge.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bridge testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_mem_axi_bridge -f filelist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
